// ==== project.f ====
rtl/rv32i_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/issue_if.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/execute_stage.sv
rtl/alu_core_top.sv
verification/clk_gen.sv
verification/alu_core_tb.sv

// ==== Bender.yml ====
package:
  name: alu_core

sources:
  - rtl/rv32i_isa_pkg.sv
  - rtl/pipe_pkg.sv
  - rtl/issue_if.sv
  - rtl/instr_decoder.sv
  - rtl/reg_file.sv
  - rtl/alu_unit.sv
  - rtl/execute_stage.sv
  - rtl/alu_core_top.sv
  - target: simulation
    files:
      - verification/clk_gen.sv
      - verification/alu_core_tb.sv

// ==== verification/alu_core_tb.sv ====
`timescale 1ns/1ns

module alu_core_tb;

  import rv32i_isa_pkg::*;

  // instructions strobed over all tests, spaced ones take 4 cycles
  localparam int num_instr   = 106;
  localparam int watchdog_ns = num_instr * 4 * 100 + 2000;

  typedef struct packed {
    int        cyc;
    reg_addr_t rd;
    xlen_t     data;
  } wb_expect_t;

  logic               clk;
  logic               reset;
  logic               instr_valid;
  logic [instr_w-1:0] instr;
  logic               wb_valid;
  reg_addr_t          wb_rd;
  xlen_t              wb_data;

  xlen_t      model_regs [num_regs];
  wb_expect_t expected [$];
  wb_expect_t head;
  int         cyc = 0;
  int         mismatch_errs = 0;
  int         other_errs = 0;

  clk_gen clk_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  alu_core_top dut_i (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  // ************************************************************
  // instruction encoding
  // ************************************************************
  function automatic logic [31:0] itype_word(input logic [2:0] f3, input reg_addr_t rd,
                                             input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input reg_addr_t rd, input reg_addr_t rs1,
                                             input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] lui_word(input reg_addr_t rd, input logic [19:0] imm20);
    return {imm20, rd, op_lui};
  endfunction

  // {funct7, funct3} of the ten OP instructions
  function automatic logic [9:0] reg_op_fields(input int idx);
    case (idx)
      0: return {7'b0, f3_add};
      1: return {f7_alt, f3_add};
      2: return {7'b0, f3_sll};
      3: return {7'b0, f3_slt};
      4: return {7'b0, f3_sltu};
      5: return {7'b0, f3_xor};
      6: return {7'b0, f3_sr};
      7: return {f7_alt, f3_sr};
      8: return {7'b0, f3_or};
      default: return {7'b0, f3_and};
    endcase
  endfunction

  // ************************************************************
  // reference model, RV32I rules on the model registers
  // ************************************************************
  function automatic logic model_result(input logic [31:0] ins, output reg_addr_t rd,
                                        output xlen_t val);
    logic [2:0] f3;
    logic       alt;
    xlen_t      a;
    xlen_t      b;
    logic [4:0] sh;
    rd  = ins[rd_hi:rd_lo];
    f3  = ins[funct3_hi:funct3_lo];
    alt = (ins[funct7_hi:funct7_lo] == f7_alt);
    a   = model_regs[ins[rs1_hi:rs1_lo]];
    val = '0;
    case (ins[opcode_hi:opcode_lo])
      op_lui: begin
        val = {ins[31:12], 12'h000};
        return 1'b1;
      end
      op_imm: begin
        b = {{20{ins[31]}}, ins[31:20]};
        // no subi, the top bits are just immediate
        if (f3 == f3_add) begin
          alt = 1'b0;
        end
      end
      op_reg: b = model_regs[ins[rs2_hi:rs2_lo]];
      default: return 1'b0;
    endcase
    sh = b[4:0];
    case (f3)
      f3_add:  val = alt ? a - b : a + b;
      f3_sll:  val = a << sh;
      f3_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_sltu: val = (a < b) ? 32'd1 : 32'd0;
      f3_xor:  val = a ^ b;
      f3_sr:   val = alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
      f3_or:   val = a | b;
      default: val = a & b;
    endcase
    return 1'b1;
  endfunction

  // ************************************************************
  // stimulus
  // ************************************************************
  task automatic strobe_instr(input logic [31:0] ins);
    reg_addr_t  rd;
    xlen_t      val;
    wb_expect_t e;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= ins;
    if (model_result(ins, rd, val)) begin
      // sampled next edge, wb seen 3 falling edges from now
      e.cyc  = cyc + 3;
      e.rd   = rd;
      e.data = val;
      expected.push_back(e);
      if (rd != '0) begin
        model_regs[rd] = val;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      instr_valid <= 1'b0;
    end
  endtask

  // lui + addi, upper part rounded for the sign of the low 12 bits
  task automatic load_reg(input reg_addr_t r, input xlen_t v, input bit spaced);
    xlen_t hi;
    hi = (v + 32'h800) >> imm_u_lo;
    strobe_instr(lui_word(r, hi[19:0]));
    if (spaced) begin
      idle_cycles(3);
    end
    strobe_instr(itype_word(f3_add, r, r, v[11:0]));
    if (spaced) begin
      idle_cycles(3);
    end
  endtask

  // ************************************************************
  // directed tests
  // ************************************************************
  task automatic check_reset();
    int unsigned samples [4] = '{0, 5, 17, 31};
    idle_cycles(8);
    foreach (samples[i]) begin
      strobe_instr(itype_word(f3_add, 5'd1, reg_addr_t'(samples[i]), 12'h000));
      idle_cycles(3);
    end
  endtask

  task automatic run_imm_group();
    reg_addr_t   rs1;
    reg_addr_t   rd;
    logic [11:0] imm;
    logic [4:0]  sh;
    // x1 negative so srai and srli differ
    load_reg(5'd1, $urandom | 32'h8000_0000, 1'b1);
    for (int r = 2; r <= 4; r++) begin
      load_reg(reg_addr_t'(r), $urandom, 1'b1);
    end
    for (int round = 0; round < 2; round++) begin
      for (int op = 0; op < 9; op++) begin
        rs1 = reg_addr_t'($urandom_range(4, 1));
        rd  = reg_addr_t'($urandom_range(12, 5));
        imm = $urandom;
        sh  = $urandom_range(31, 0);
        if (round == 1) begin
          imm[11] = 1'b1;
        end
        case (op)
          0: strobe_instr(itype_word(f3_add, rd, rs1, imm));
          1: strobe_instr(itype_word(f3_slt, rd, rs1, imm));
          2: strobe_instr(itype_word(f3_sltu, rd, rs1, imm));
          3: strobe_instr(itype_word(f3_xor, rd, rs1, imm));
          4: strobe_instr(itype_word(f3_or, rd, rs1, imm));
          5: strobe_instr(itype_word(f3_and, rd, rs1, imm));
          6: strobe_instr(itype_word(f3_sll, rd, rs1, {7'b0, sh}));
          7: strobe_instr(itype_word(f3_sr, rd, 5'd1, {7'b0, sh}));
          default: strobe_instr(itype_word(f3_sr, rd, 5'd1, {f7_alt, sh}));
        endcase
        idle_cycles(3);
      end
    end
  endtask

  task automatic run_reg_group();
    logic [9:0] f;
    for (int r = 1; r <= 3; r++) begin
      load_reg(reg_addr_t'(r), $urandom, 1'b1);
    end
    // signed boundary, x22 equal to x20
    load_reg(5'd20, 32'h8000_0000, 1'b1);
    load_reg(5'd21, 32'h7fff_ffff, 1'b1);
    load_reg(5'd22, 32'h8000_0000, 1'b1);
    for (int round = 0; round < 2; round++) begin
      for (int op = 0; op < 10; op++) begin
        f = reg_op_fields(op);
        strobe_instr(rtype_word(f[9:3], f[2:0], reg_addr_t'($urandom_range(12, 5)),
                                reg_addr_t'($urandom_range(3, 1)),
                                reg_addr_t'($urandom_range(3, 1))));
        idle_cycles(3);
      end
    end
    for (int op = 3; op <= 4; op++) begin
      f = reg_op_fields(op);
      strobe_instr(rtype_word(f[9:3], f[2:0], 5'd8, 5'd20, 5'd21));
      idle_cycles(3);
      strobe_instr(rtype_word(f[9:3], f[2:0], 5'd9, 5'd21, 5'd20));
      idle_cycles(3);
      strobe_instr(rtype_word(f[9:3], f[2:0], 5'd10, 5'd20, 5'd22));
      idle_cycles(3);
    end
  endtask

  task automatic run_chains();
    reg_addr_t  rd;
    reg_addr_t  prev1;
    reg_addr_t  prev2;
    logic [9:0] f;
    load_reg(5'd10, $urandom, 1'b0);
    strobe_instr(rtype_word(7'b0, f3_add, 5'd11, 5'd10, 5'd10));
    strobe_instr(rtype_word(7'b0, f3_xor, 5'd12, 5'd10, 5'd11));
    strobe_instr(rtype_word(f7_alt, f3_add, 5'd13, 5'd11, 5'd12));
    strobe_instr(rtype_word(f7_alt, f3_sr, 5'd14, 5'd13, 5'd12));
    // rs1 one behind, rs2 two behind
    prev2 = 5'd13;
    prev1 = 5'd14;
    repeat (24) begin
      rd = reg_addr_t'($urandom_range(19, 16));
      f  = reg_op_fields($urandom_range(9, 0));
      strobe_instr(rtype_word(f[9:3], f[2:0], rd, prev1, prev2));
      prev2 = prev1;
      prev1 = rd;
    end
    strobe_instr(itype_word(f3_add, 5'd0, 5'd0, 12'd123));
    strobe_instr(rtype_word(7'b0, f3_add, 5'd15, 5'd0, 5'd0));
    idle_cycles(4);
  endtask

  task automatic run_lui_unsupported();
    logic [31:0] junk;
    strobe_instr(lui_word(5'd23, $urandom));
    junk = $urandom;
    strobe_instr({junk[31:7], 7'b0000011});
    strobe_instr(rtype_word(7'b0, f3_add, 5'd24, 5'd23, 5'd23));
    junk = $urandom;
    strobe_instr({junk[31:7], 7'b1100011});
    strobe_instr(itype_word(f3_add, 5'd25, 5'd24, 12'd1));
    strobe_instr(lui_word(5'd26, $urandom));
    idle_cycles(4);
  endtask

  // ************************************************************
  // writeback monitor, falling edge
  // ************************************************************
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (reset === 1'b1) begin
      assert (wb_valid !== 1'b1) else begin
        other_errs++;
        $display("wb_valid went high during reset at %0t ns", $time);
      end
    end else if (wb_valid) begin
      assert (expected.size() > 0) else begin
        other_errs++;
        $display("unexpected writeback to x%0d at %0t ns", wb_rd, $time);
      end
      if (expected.size() > 0) begin
        head = expected.pop_front();
        assert (wb_rd == head.rd) else begin
          mismatch_errs++;
          $display("Mismatch at %0t ns: wb_rd = %0d, expected %0d", $time, wb_rd, head.rd);
        end
        assert (wb_data == head.data) else begin
          mismatch_errs++;
          $display("Mismatch at %0t ns: wb_data = %h, expected %h", $time, wb_data,
                   head.data);
        end
        assert (cyc == head.cyc) else begin
          other_errs++;
          $display("writeback to x%0d came at cycle %0d instead of cycle %0d",
                   head.rd, cyc, head.cyc);
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    void'($urandom(40924));
    wait (reset == 1'b0);
    check_reset();
    run_imm_group();
    run_reg_group();
    run_chains();
    run_lui_unsupported();
    idle_cycles(4);
    assert (expected.size() == 0) else begin
      other_errs++;
      $display("%0d expected writebacks never arrived", expected.size());
    end
    $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/clk_gen.sv ====
`timescale 1ns/1ns

module clk_gen #(
  parameter int period       = 100,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // released on a rising edge, like a synchronous reset source
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== rtl/alu_core_top.sv ====
`timescale 1ns/1ns

module alu_core_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              instr_valid,
  input  logic [rv32i_isa_pkg::instr_w-1:0] instr,
  output logic                              wb_valid,
  output rv32i_isa_pkg::reg_addr_t          wb_rd,
  output rv32i_isa_pkg::xlen_t              wb_data
);

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  reg_addr_t rs1_idx;
  reg_addr_t rs2_idx;
  xlen_t     rs1_val;
  xlen_t     rs2_val;
  result_t   result;

  issue_if issue_bus ();

  // decode / register read
  instr_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .issue       (issue_bus.decode)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wr      (result)
  );

  execute_stage u_execute (
    .clk    (clk),
    .reset  (reset),
    .issue  (issue_bus.execute),
    .result (result)
  );

  // writeback strobe straight off the result register
  assign wb_valid = result.valid;
  assign wb_rd    = result.rd;
  assign wb_data  = result.data;

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic               clk,
  input  logic               reset,
  issue_if.execute           issue,
  output pipe_pkg::result_t  result
);

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic  fwd_ok;
  xlen_t op_a;
  xlen_t rs2_fwd;
  xlen_t op_b;
  xlen_t alu_y;

  // ********************************************************
  // forwarding from the result register
  // ********************************************************
  // the instruction just ahead sits in result; two ahead was
  // already bypassed by the register file at decode
  assign fwd_ok = result.valid && result.we;

  always_comb begin
    op_a = issue.rs1_val;
    if (fwd_ok && result.rd == issue.rs1_idx) begin
      op_a = result.data;
    end

    rs2_fwd = issue.rs2_val;
    if (fwd_ok && result.rd == issue.rs2_idx) begin
      rs2_fwd = result.data;
    end

    op_b = issue.use_imm ? issue.imm : rs2_fwd;
  end

  alu_unit u_alu (
    .op (issue.alu_op),
    .a  (op_a),
    .b  (op_b),
    .y  (alu_y)
  );

  // ********************************************************
  // result register
  // ********************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= issue.valid;
    end

    if (issue.valid) begin
      result.we   <= issue.we;
      result.rd   <= issue.rd;
      result.data <= alu_y;
    end
  end

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
  input  pipe_pkg::alu_op_t    op,
  input  rv32i_isa_pkg::xlen_t a,
  input  rv32i_isa_pkg::xlen_t b,
  output rv32i_isa_pkg::xlen_t y
);

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic [shamt_w-1:0] shamt;

  // only the low bits of b count for shifts
  assign shamt = b[shamt_w-1:0];

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_sll:    y = a << shamt;
      alu_slt:    y = xlen_t'($signed(a) < $signed(b));
      alu_sltu:   y = xlen_t'(a < b);
      alu_xor:    y = a ^ b;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = xlen_t'($signed(a) >>> shamt);
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      alu_pass_b: y = b;
      default:    y = '0;
    endcase
  end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                     clk,
  input  logic                     reset,
  input  rv32i_isa_pkg::reg_addr_t rs1_idx,
  input  rv32i_isa_pkg::reg_addr_t rs2_idx,
  output rv32i_isa_pkg::xlen_t     rs1_val,
  output rv32i_isa_pkg::xlen_t     rs2_val,
  input  pipe_pkg::result_t        wr
);

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  xlen_t regs [num_regs];
  logic  wr_en;

  assign wr_en = wr.valid && wr.we;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // x0 reads zero, then write-first bypass, then the array
  always_comb begin
    rs1_val = regs[rs1_idx];
    if (rs1_idx == '0) begin
      rs1_val = '0;
    end else if (wr_en && wr.rd == rs1_idx) begin
      rs1_val = wr.data;
    end

    rs2_val = regs[rs2_idx];
    if (rs2_idx == '0) begin
      rs2_val = '0;
    end else if (wr_en && wr.rd == rs2_idx) begin
      rs2_val = wr.data;
    end
  end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              instr_valid,
  input  logic [rv32i_isa_pkg::instr_w-1:0] instr,
  output rv32i_isa_pkg::reg_addr_t          rs1_idx,
  output rv32i_isa_pkg::reg_addr_t          rs2_idx,
  input  rv32i_isa_pkg::xlen_t              rs1_val,
  input  rv32i_isa_pkg::xlen_t              rs2_val,
  issue_if.decode                           issue
);

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic [opcode_w-1:0] opcode;
  logic [funct3_w-1:0] funct3;
  logic [funct7_w-1:0] funct7;
  reg_addr_t           rd;
  xlen_t               i_imm;
  xlen_t               u_imm;
  xlen_t               imm;
  logic                use_imm;
  logic                supported;
  alu_op_t             alu_op;

  // shared by op-imm and op; only op has sub
  function automatic alu_op_t map_funct(input logic [funct3_w-1:0] f3,
                                        input logic [funct7_w-1:0] f7,
                                        input logic is_imm);
    alu_op_t op;
    case (f3)
      f3_add:  op = (!is_imm && f7 == f7_alt) ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = (f7 == f7_alt) ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      f3_and:  op = alu_and;
      default: op = alu_add;
    endcase
    return op;
  endfunction

  // ********************************************************
  // field extraction and control
  // ********************************************************
  always_comb begin
    opcode  = instr[opcode_hi:opcode_lo];
    funct3  = instr[funct3_hi:funct3_lo];
    funct7  = instr[funct7_hi:funct7_lo];
    rd      = instr[rd_hi:rd_lo];
    rs2_idx = instr[rs2_hi:rs2_lo];
    i_imm   = {{(xlen - imm_i_w){instr[instr_w-1]}}, instr[instr_w-1:imm_i_lo]};
    u_imm   = {instr[instr_w-1:imm_u_lo], {imm_u_lo{1'b0}}};

    rs1_idx   = instr[rs1_hi:rs1_lo];
    imm       = i_imm;
    use_imm   = 1'b0;
    supported = 1'b1;
    alu_op    = alu_add;

    case (opcode)
      op_imm: begin
        use_imm = 1'b1;
        alu_op  = map_funct(funct3, funct7, 1'b1);
      end
      op_reg: alu_op = map_funct(funct3, funct7, 1'b0);
      op_lui: begin
        // rs1 field is immediate bits here
        rs1_idx = '0;
        imm     = u_imm;
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
      end
      default: supported = 1'b0;
    endcase
  end

  // ********************************************************
  // issue register
  // ********************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= instr_valid && supported;
    end

    if (instr_valid) begin
      issue.alu_op  <= alu_op;
      issue.rd      <= rd;
      issue.we      <= (rd != '0);
      issue.rs1_idx <= rs1_idx;
      issue.rs2_idx <= rs2_idx;
      issue.rs1_val <= rs1_val;
      issue.rs2_val <= rs2_val;
      issue.imm     <= imm;
      issue.use_imm <= use_imm;
    end
  end

endmodule

// ==== rtl/issue_if.sv ====
`timescale 1ns/1ns

interface issue_if;

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic      valid;
  alu_op_t   alu_op;
  reg_addr_t rd;
  logic      we;
  reg_addr_t rs1_idx;
  reg_addr_t rs2_idx;
  xlen_t     rs1_val;
  xlen_t     rs2_val;
  xlen_t     imm;
  logic      use_imm;

  modport decode (output valid, alu_op, rd, we, rs1_idx, rs2_idx,
                  rs1_val, rs2_val, imm, use_imm);
  modport execute (input valid, alu_op, rd, we, rs1_idx, rs2_idx,
                   rs1_val, rs2_val, imm, use_imm);

endinterface

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

  import rv32i_isa_pkg::*;

  // ********************************************************
  // alu operations
  // ********************************************************
  localparam int alu_op_w = 4;

  typedef enum logic [alu_op_w-1:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui goes through here
    alu_pass_b
  } alu_op_t;

  // ********************************************************
  // finished instruction, out of execute
  // ********************************************************
  typedef struct packed {
    logic      valid;
    // already low for rd == x0
    logic      we;
    reg_addr_t rd;
    xlen_t     data;
  } result_t;

endpackage

// ==== rtl/rv32i_isa_pkg.sv ====
package rv32i_isa_pkg;

  // ********************************************************
  // widths
  // ********************************************************
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;
  localparam int instr_w    = 32;
  localparam int opcode_w   = 7;
  localparam int funct3_w   = 3;
  localparam int funct7_w   = 7;
  localparam int shamt_w    = $clog2(xlen);

  typedef logic [xlen-1:0]       xlen_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // ********************************************************
  // opcodes and function codes
  // ********************************************************
  localparam logic [opcode_w-1:0] op_imm = 7'b0010011;
  localparam logic [opcode_w-1:0] op_reg = 7'b0110011;
  localparam logic [opcode_w-1:0] op_lui = 7'b0110111;

  localparam logic [funct3_w-1:0] f3_add  = 3'b000;
  localparam logic [funct3_w-1:0] f3_sll  = 3'b001;
  localparam logic [funct3_w-1:0] f3_slt  = 3'b010;
  localparam logic [funct3_w-1:0] f3_sltu = 3'b011;
  localparam logic [funct3_w-1:0] f3_xor  = 3'b100;
  localparam logic [funct3_w-1:0] f3_sr   = 3'b101;
  localparam logic [funct3_w-1:0] f3_or   = 3'b110;
  localparam logic [funct3_w-1:0] f3_and  = 3'b111;

  // sub and sra / srai
  localparam logic [funct7_w-1:0] f7_alt = 7'b0100000;

  // ********************************************************
  // instruction field positions
  // ********************************************************
  localparam int opcode_lo = 0;
  localparam int opcode_hi = opcode_lo + opcode_w - 1;
  localparam int rd_lo     = 7;
  localparam int rd_hi     = rd_lo + reg_addr_w - 1;
  localparam int funct3_lo = 12;
  localparam int funct3_hi = funct3_lo + funct3_w - 1;
  localparam int rs1_lo    = 15;
  localparam int rs1_hi    = rs1_lo + reg_addr_w - 1;
  localparam int rs2_lo    = 20;
  localparam int rs2_hi    = rs2_lo + reg_addr_w - 1;
  localparam int funct7_lo = 25;
  localparam int funct7_hi = funct7_lo + funct7_w - 1;
  localparam int imm_i_lo  = 20;
  localparam int imm_i_w   = instr_w - imm_i_lo;
  localparam int imm_u_lo  = 12;

endpackage
